/* source/fetch_pkg.sv */
package fetch_pkg;

    // byte address of a fetch
    typedef logic [31:0] addr_t;
    // one LA32R instruction word
    typedef logic [31:0] inst_t;

    // execution unit an instruction is steered to
    typedef enum logic [3:0] {
        unit_alu,
        unit_br,
        unit_div,
        unit_priv,
        unit_mul,
        unit_dcache,
        unit_rdcnt,
        unit_illegal
    } unit_e;

    // one issue slot as seen by decode
    typedef struct packed {
        logic  valid;
        addr_t pc;
        inst_t inst;
        unit_e unit;
    } fetch_slot_t;

    // slot0 in the low half, same order as the raw word pair
    typedef struct packed {
        fetch_slot_t slot1;
        fetch_slot_t slot0;
    } fetch_pair_t;

    // defaults for the module parameters
    // the top level passes its own values down
    parameter addr_t       reset_pc   = 32'h0000_0000;
    parameter int unsigned prog_words = 8;

    // major opcode prefixes, taken from the top of the word
    localparam logic [9:0]  op_addi_w = 10'b0000001010;
    localparam logic [9:0]  op_ld_b   = 10'b0010100000;
    localparam logic [9:0]  op_ld_h   = 10'b0010100001;
    localparam logic [9:0]  op_ld_w   = 10'b0010100010;
    localparam logic [5:0]  op_beq    = 6'b010110;
    localparam logic [5:0]  op_bne    = 6'b010111;
    localparam logic [16:0] op_mul_w  = 17'b00000000000111000;
    localparam logic [16:0] op_div_w  = 17'b00000000001000000;
    localparam logic [16:0] op_rdcnt  = 17'b00000000000000000;
    // csrrd, csrwr and csrxchg share this prefix
    localparam logic [7:0]  op_csr    = 8'b00000100;

    // addi.w r0,r0,0
    localparam inst_t nop_inst = 32'b0000001010_000000000000_00000_00000;

    // test program from byte address 0, one word per entry
    localparam inst_t prog_rom [0:prog_words-1] = '{
        32'b0000001010_000000010000_00001_00001,  // addi.w r1,r1,16
        32'b0010100010_000000000001_00010_00011,  // ld.w r3,r2,1
        32'b010111_1111111111111110_00010_00001,  // bne r2,r1,-2
        32'b00000000000111000_00011_00010_00101,  // mul.w r5,r2,r3
        32'b00000000001000000_00010_00101_00110,  // div.w r6,r5,r2
        32'b00000100_00000000000001_00000_00111,  // csrrd r7,0x1
        32'b0000000000000000011000_00000_01000,   // rdcntvl.w r8
        32'b0010100000_000000000001_00011_00100   // ld.b r4,r3,1
    };

endpackage

/* source/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen #(
    parameter fetch_pkg::addr_t reset_pc = fetch_pkg::reset_pc
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             stall,
    input  logic             flush,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             step_pair,
    output fetch_pkg::addr_t pc
);

    import fetch_pkg::*;

    // one instruction is four bytes
    localparam addr_t inst_bytes = 32'd4;

    addr_t step;
    addr_t pc_next;

    // two words when the pair may dual issue, else only one
    always_comb begin
        step    = step_pair ? (inst_bytes << 1) : inst_bytes;
        pc_next = pc + step;
    end

    // flush beats stall
    // the redirect target is taken even while the front end is frozen
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc <= reset_pc;
        end else if (flush) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            // pc already runs one pair ahead of the output register
            pc <= pc_next;
        end
    end

    // reset value and redirect targets come from outside
    // a misaligned one would break the table index in the stub
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rstn)
        pc[1:0] == 2'b00
    ) else $error("pc_gen: pc %h not word aligned", pc);

endmodule

/* source/icache_stub.sv */
`timescale 1ns/1ps

module icache_stub #(
    parameter int unsigned prog_words = fetch_pkg::prog_words
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  stall,
    input  logic                  flush,
    input  fetch_pkg::addr_t      pc,
    output logic                  step_pair,
    output fetch_pkg::inst_t [1:0] ir_pair,
    output fetch_pkg::addr_t      pair_pc,
    output logic                  second_ok,
    output logic                  line_valid
);

    import fetch_pkg::*;

    // never read past the end of the table itself
    localparam int unsigned rom_len =
        (prog_words < $size(prog_rom)) ? prog_words : $size(prog_rom);

    addr_t        idx0;
    addr_t        idx1;
    inst_t [1:0]  ir_next;
    logic         pair_ok;

    // word at a given index
    // nop past the program
    function automatic inst_t rom_word(input addr_t idx);
        inst_t word;
        word = nop_inst;
        for (int unsigned i = 0; i < rom_len; i++) begin
            if (idx == addr_t'(i)) begin
                word = prog_rom[i];
            end
        end
        return word;
    endfunction

    // lookup of the addressed word and the one after it
    always_comb begin
        idx0       = {2'b00, pc[31:2]};
        idx1       = idx0 + 32'd1;
        ir_next[0] = rom_word(idx0);
        ir_next[1] = rom_word(idx1);
        // second word issues only from an 8 byte aligned pair
        pair_ok    = ~pc[2];
    end

    // pc_gen steps on this before the output register sees it
    assign step_pair = pair_ok;

    // control flops
    // the stub has no misses, so every address gives a valid line
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            line_valid <= 1'b0;
            second_ok  <= 1'b0;
        end else if (flush) begin
            // bubble for the cycle after a redirect
            line_valid <= 1'b0;
            second_ok  <= 1'b0;
        end else if (!stall) begin
            line_valid <= 1'b1;
            second_ok  <= pair_ok;
        end
    end

    // payload flops
    // zeroed on reset and flush along with the control bits
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ir_pair <= '0;
            pair_pc <= '0;
        end else if (flush) begin
            ir_pair <= '0;
            pair_pc <= '0;
        end else if (!stall) begin
            ir_pair <= ir_next;
            pair_pc <= pc;
        end
    end

    // pairing without a line would hand decode a lone slot1
    a_second_needs_line: assert property (
        @(posedge clk) disable iff (!rstn)
        second_ok |-> line_valid
    ) else $error("icache_stub: second_ok without line_valid");

    // frozen outputs for every held cycle
    // a flush on a stalled edge still clears them
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (stall && !flush) |=> $stable({ir_pair, pair_pc, second_ok, line_valid})
    ) else $error("icache_stub: outputs moved under stall");

endmodule

/* source/predecode.sv */
`timescale 1ns/1ps

module predecode (
    input  fetch_pkg::inst_t [1:0] ir_pair,
    input  fetch_pkg::addr_t       pair_pc,
    input  logic                   second_ok,
    input  logic                   line_valid,
    output fetch_pkg::fetch_pair_t fetch_out
);

    import fetch_pkg::*;

    // rdcnt group sits under an all zero prefix
    // bits 14:11 pick it out from the rest of that space
    localparam logic [3:0] rdcnt_sub = 4'b1100;

    // slot1 sits one word above slot0
    localparam addr_t inst_bytes = 32'd4;

    // sort a word into its execution unit
    // prefixes do not overlap so the order is free
    function automatic unit_e classify(input inst_t w);
        unit_e cls;
        cls = unit_illegal;
        if (w[31:22] == op_addi_w) begin
            cls = unit_alu;
        end else if (w[31:22] == op_ld_b ||
                     w[31:22] == op_ld_h ||
                     w[31:22] == op_ld_w) begin
            // loads go to the data cache port
            cls = unit_dcache;
        end else if (w[31:26] == op_beq || w[31:26] == op_bne) begin
            cls = unit_br;
        end else if (w[31:15] == op_mul_w) begin
            cls = unit_mul;
        end else if (w[31:15] == op_div_w) begin
            // iterative divider, long latency
            cls = unit_div;
        end else if (w[31:24] == op_csr) begin
            // csr access serialises, handled as privileged
            cls = unit_priv;
        end else if (w[31:15] == op_rdcnt && w[14:11] == rdcnt_sub) begin
            cls = unit_rdcnt;
        end
        return cls;
    endfunction

    // pack both slots without a register
    always_comb begin
        // slot0 follows the line alone
        fetch_out.slot0.valid = line_valid;
        fetch_out.slot0.pc    = pair_pc;
        fetch_out.slot0.inst  = ir_pair[0];
        fetch_out.slot0.unit  = classify(ir_pair[0]);

        // slot1 also needs the pairing flag
        fetch_out.slot1.valid = line_valid & second_ok;
        fetch_out.slot1.pc    = pair_pc + inst_bytes;
        fetch_out.slot1.inst  = ir_pair[1];
        fetch_out.slot1.unit  = classify(ir_pair[1]);
    end

    // decode issues in order
    // a lone slot1 would run ahead of its older neighbour
    always_comb begin
        assert (!fetch_out.slot1.valid || fetch_out.slot0.valid)
        else $error("predecode: slot1 valid at %h with slot0 invalid",
                    fetch_out.slot1.pc);
    end

endmodule

/* source/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top #(
    parameter fetch_pkg::addr_t reset_pc   = fetch_pkg::reset_pc,
    parameter int unsigned      prog_words = fetch_pkg::prog_words
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   stall,
    input  logic                   flush,
    input  fetch_pkg::addr_t       redirect_pc,
    output fetch_pkg::fetch_pair_t fetch_out
);

    import fetch_pkg::*;

    // current fetch address, one pair ahead of fetch_out
    addr_t       pc;
    // combinational pairing flag back to the pc stepper
    logic        step_pair;
    // registered pair from the stub
    inst_t [1:0] ir_pair;
    addr_t       pair_pc;
    logic        second_ok;
    logic        line_valid;

    pc_gen #(
        .reset_pc    (reset_pc)
    ) pc_gen0 (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .step_pair   (step_pair),
        .pc          (pc)
    );

    icache_stub #(
        .prog_words  (prog_words)
    ) icache0 (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .flush       (flush),
        .pc          (pc),
        .step_pair   (step_pair),
        .ir_pair     (ir_pair),
        .pair_pc     (pair_pc),
        .second_ok   (second_ok),
        .line_valid  (line_valid)
    );

    // zero latency
    // fetch_out changes with the stub registers
    predecode predecode0 (
        .ir_pair     (ir_pair),
        .pair_pc     (pair_pc),
        .second_ok   (second_ok),
        .line_valid  (line_valid),
        .fetch_out   (fetch_out)
    );

endmodule

/* test/fetch_tests.svh */
`ifndef FETCH_TESTS_SVH
`define FETCH_TESTS_SVH

// empty outputs in reset
// first pair at the reset pc
task automatic reset_test();
    test_errs   = 0;
    exp_pc      = start_pc;
    exp_pair_pc = 32'h0;
    exp_line    = 1'b0;
    exp_second  = 1'b0;
    repeat (4) begin
        @(negedge clk);
        if (fetch_out.slot0.valid !== 1'b0)
            report_mismatch("slot0.valid", 32'(fetch_out.slot0.valid), 32'h0);
        if (fetch_out.slot1.valid !== 1'b0)
            report_mismatch("slot1.valid", 32'(fetch_out.slot1.valid), 32'h0);
    end
    @(posedge clk);
    rstn <= 1'b1;
    // release edge still sees reset low
    @(negedge clk);
    check_output();
    last_out = fetch_out;
    model_step(1'b0, 1'b0, 32'h0);
    run_cycle(1'b0, 1'b0, 32'h0);
    if (fetch_out.slot0.pc !== start_pc)
        report_mismatch("slot0.pc", fetch_out.slot0.pc, start_pc);
    if (fetch_out.slot1.valid !== 1'b1)
        report_mismatch("slot1.valid", 32'(fetch_out.slot1.valid), 32'h1);
    report_test("reset");
endtask

// pairs at 0, 8, 16 and on past the table
task automatic stream_test();
    addr_t want;
    test_errs = 0;
    run_cycle(1'b0, 1'b1, 32'h0);
    run_cycle(1'b0, 1'b0, 32'h0);
    for (int k = 0; k < rom_words / 2 + 2; k++) begin
        run_cycle(1'b0, 1'b0, 32'h0);
        want = 8 * k;
        if (fetch_out.slot0.pc !== want)
            report_mismatch("slot0.pc", fetch_out.slot0.pc, want);
        if (fetch_out.slot1.pc !== want + 32'd4)
            report_mismatch("slot1.pc", fetch_out.slot1.pc, want + 32'd4);
    end
    // last pair lies beyond the program
    if (fetch_out.slot0.inst !== nop_inst)
        report_mismatch("slot0.inst", fetch_out.slot0.inst, nop_inst);
    if (fetch_out.slot1.inst !== nop_inst)
        report_mismatch("slot1.inst", fetch_out.slot1.inst, nop_inst);
    report_test("sequential stream");
endtask

// odd word target gives a lone slot0
// pairing resumes on the pair after it
task automatic odd_redirect_test();
    addr_t target;
    test_errs = 0;
    for (int n = 0; n < 4; n++) begin
        target = addr_t'({$random(seed)} % rom_words);
        target = (target | 32'd1) << 2;
        run_cycle(1'b0, 1'b1, target);
        run_cycle(1'b0, 1'b0, 32'h0);
        // bubble in the cycle after the flush
        if (fetch_out.slot0.valid !== 1'b0)
            report_mismatch("slot0.valid", 32'(fetch_out.slot0.valid), 32'h0);
        if (fetch_out.slot1.valid !== 1'b0)
            report_mismatch("slot1.valid", 32'(fetch_out.slot1.valid), 32'h0);
        run_cycle(1'b0, 1'b0, 32'h0);
        if (fetch_out.slot0.pc !== target)
            report_mismatch("slot0.pc", fetch_out.slot0.pc, target);
        if (fetch_out.slot1.valid !== 1'b0)
            report_mismatch("slot1.valid", 32'(fetch_out.slot1.valid), 32'h0);
        run_cycle(1'b0, 1'b0, 32'h0);
        if (fetch_out.slot0.pc !== target + 32'd4)
            report_mismatch("slot0.pc", fetch_out.slot0.pc, target + 32'd4);
        if (fetch_out.slot1.valid !== 1'b1)
            report_mismatch("slot1.valid", 32'(fetch_out.slot1.valid), 32'h1);
    end
    report_test("odd redirect");
endtask

// hold and sequence checked on every cycle of a random stall pattern
task automatic stall_hold_test();
    integer r;
    int     held;
    test_errs = 0;
    held      = 0;
    run_cycle(1'b0, 1'b1, 32'h0);
    run_cycle(1'b0, 1'b0, 32'h0);
    for (int n = 0; n < 28; n++) begin
        r = $random(seed);
        held += r[0];
        run_cycle(r[0], 1'b0, 32'h0);
    end
    // drain with the stall released
    run_cycle(1'b0, 1'b0, 32'h0);
    run_cycle(1'b0, 1'b0, 32'h0);
    if (held == 0) begin
        $display("stall pattern never asserted stall");
        test_errs++;
    end
    report_test("stall hold");
endtask

// every table word in slot0 or slot1
// followed by one nop pair
task automatic unit_class_test();
    addr_t want;
    test_errs = 0;
    run_cycle(1'b0, 1'b1, 32'h0);
    run_cycle(1'b0, 1'b0, 32'h0);
    for (int k = 0; k <= rom_words / 2; k++) begin
        run_cycle(1'b0, 1'b0, 32'h0);
        want = 8 * k;
        if (fetch_out.slot0.unit !== expected_unit(want))
            report_mismatch("slot0.unit", 32'(fetch_out.slot0.unit),
                            32'(expected_unit(want)));
        if (fetch_out.slot1.unit !== expected_unit(want + 32'd4))
            report_mismatch("slot1.unit", 32'(fetch_out.slot1.unit),
                            32'(expected_unit(want + 32'd4)));
    end
    if (fetch_out.slot0.unit !== unit_alu)
        report_mismatch("slot0.unit", 32'(fetch_out.slot0.unit), 32'(unit_alu));
    report_test("unit classification");
endtask

// flush while stalled must still redirect
task automatic flush_over_stall_test();
    addr_t target;
    test_errs = 0;
    for (int n = 0; n < 3; n++) begin
        target = addr_t'({$random(seed)} % rom_words) << 2;
        run_cycle(1'b1, 1'b0, 32'h0);
        run_cycle(1'b1, 1'b1, target);
        run_cycle(1'b0, 1'b0, 32'h0);
        run_cycle(1'b0, 1'b0, 32'h0);
        if (fetch_out.slot0.valid !== 1'b1)
            report_mismatch("slot0.valid", 32'(fetch_out.slot0.valid), 32'h1);
        if (fetch_out.slot0.pc !== target)
            report_mismatch("slot0.pc", fetch_out.slot0.pc, target);
    end
    report_test("flush over stall");
endtask

`endif

/* test/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

    import fetch_pkg::*;

    localparam addr_t       start_pc  = 32'h0000_0000;
    localparam int unsigned rom_words = 8;
    localparam int          rom_abits = $clog2(rom_words);

    // cycle budget of each test
    // the watchdog limit is their sum
    localparam int reset_budget  = 6;
    localparam int stream_budget = 10;
    localparam int odd_budget    = 20;
    localparam int stall_budget  = 34;
    localparam int class_budget  = 8;
    localparam int fos_budget    = 12;
    localparam int total_budget  = reset_budget + stream_budget + odd_budget +
                                   stall_budget + class_budget + fos_budget;

    logic        clk;
    logic        rstn;
    logic        stall;
    logic        flush;
    addr_t       redirect_pc;
    fetch_pair_t fetch_out;

    // model of pc and of the stub output register
    addr_t exp_pc;
    addr_t exp_pair_pc;
    logic  exp_line;
    logic  exp_second;

    // inputs taken on the last edge, and the output before it
    logic        applied_stall;
    logic        applied_flush;
    fetch_pair_t last_out;

    integer seed;
    int     test_errs;
    int     total_errs;
    int     tests_passed;
    int     tests_failed;

    fetch_top #(
        .reset_pc    (start_pc),
        .prog_words  (rom_words)
    ) dut0 (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .fetch_out   (fetch_out)
    );

    always #5 clk = ~clk;

    // watchdog at the budget plus some slack
    initial begin
        #((total_budget + 50) * 10);
        $display("timeout, tests still running after %0d cycles", total_budget + 50);
        $display("Test FAILED");
        $finish;
    end

    // program word at a byte address
    // nop past the table
    function automatic inst_t expected_word(input addr_t a);
        inst_t              w;
        logic [rom_abits-1:0] sel;
        w   = nop_inst;
        sel = a[rom_abits+1:2];
        if ((a >> 2) < rom_words) begin
            w = prog_rom[sel];
        end
        return w;
    endfunction

    // documented unit of each program word
    function automatic unit_e expected_unit(input addr_t a);
        unit_e cls;
        case (a >> 2)
            0: cls = unit_alu;      // addi.w
            1: cls = unit_dcache;   // ld.w
            2: cls = unit_br;       // bne
            3: cls = unit_mul;
            4: cls = unit_div;
            5: cls = unit_priv;     // csrrd
            6: cls = unit_rdcnt;
            7: cls = unit_dcache;   // ld.b
            // nop words past the program
            default: cls = unit_alu;
        endcase
        return cls;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] %s: got %h expected %h", name, got, exp);
        test_errs++;
    endtask

    // one edge of the front end as seen from outside
    task automatic model_step(input logic s, input logic f, input addr_t r);
        if (f) begin
            exp_pc      = r;
            exp_pair_pc = 32'h0;
            exp_line    = 1'b0;
            exp_second  = 1'b0;
        end else if (!s) begin
            exp_pair_pc = exp_pc;
            exp_line    = 1'b1;
            // pairs only from an 8 byte boundary
            exp_second  = ~exp_pc[2];
            exp_pc      = exp_pc + (exp_pc[2] ? 32'd4 : 32'd8);
        end
    endtask

    task automatic check_output();
        addr_t pc1;
        pc1 = exp_pair_pc + 32'd4;
        if (fetch_out.slot0.valid !== exp_line)
            report_mismatch("slot0.valid", 32'(fetch_out.slot0.valid), 32'(exp_line));
        if (fetch_out.slot1.valid !== (exp_line & exp_second))
            report_mismatch("slot1.valid", 32'(fetch_out.slot1.valid),
                            32'(exp_line & exp_second));
        if (exp_line) begin
            if (fetch_out.slot0.pc !== exp_pair_pc)
                report_mismatch("slot0.pc", fetch_out.slot0.pc, exp_pair_pc);
            if (fetch_out.slot0.inst !== expected_word(exp_pair_pc))
                report_mismatch("slot0.inst", fetch_out.slot0.inst,
                                expected_word(exp_pair_pc));
            if (fetch_out.slot0.unit !== expected_unit(exp_pair_pc))
                report_mismatch("slot0.unit", 32'(fetch_out.slot0.unit),
                                32'(expected_unit(exp_pair_pc)));
        end
        if (exp_line && exp_second) begin
            if (fetch_out.slot1.pc !== pc1)
                report_mismatch("slot1.pc", fetch_out.slot1.pc, pc1);
            if (fetch_out.slot1.inst !== expected_word(pc1))
                report_mismatch("slot1.inst", fetch_out.slot1.inst, expected_word(pc1));
            if (fetch_out.slot1.unit !== expected_unit(pc1))
                report_mismatch("slot1.unit", 32'(fetch_out.slot1.unit),
                                32'(expected_unit(pc1)));
        end
        // a stalled edge must leave the whole output alone
        if (applied_stall && !applied_flush && fetch_out !== last_out) begin
            $display("[FAIL] fetch_out: got %h expected %h", fetch_out, last_out);
            test_errs++;
        end
    endtask

    // inputs set here act on the next edge
    // that edge is checked on the negedge after it
    task automatic run_cycle(input logic s, input logic f, input addr_t r);
        @(posedge clk);
        stall       <= s;
        flush       <= f;
        redirect_pc <= r;
        @(negedge clk);
        check_output();
        last_out      = fetch_out;
        applied_stall = s;
        applied_flush = f;
        model_step(s, f, r);
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errs);
        end
        total_errs += test_errs;
    endtask

    `include "fetch_tests.svh"

    initial begin
        seed          = 32'h179ed258;
        clk           = 1'b0;
        rstn          = 1'b0;
        stall         = 1'b0;
        flush         = 1'b0;
        redirect_pc   = 32'h0;
        applied_stall = 1'b0;
        applied_flush = 1'b0;
        last_out      = '0;
        test_errs     = 0;
        total_errs    = 0;
        tests_passed  = 0;
        tests_failed  = 0;

        reset_test();
        stream_test();
        odd_redirect_test();
        stall_hold_test();
        unit_class_test();
        flush_over_stall_test();

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* lacore_fetch.f */
+incdir+test
source/fetch_pkg.sv
source/pc_gen.sv
source/icache_stub.sv
source/predecode.sv
source/fetch_top.sv
test/fetch_tb.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench
# any variable below can be set on the make command line

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= lacore_fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Test OK" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
